// ==== cpu.f ====
verilog/cpu_pkg.sv
verilog/stage_reg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/register_bank.sv
verilog/execute.sv
verilog/memory.sv
verilog/data_ram.sv
verilog/cpu.sv
dv/cpu_tb.sv

// ==== Makefile ====
TOP             ?= cpu_tb
FILELIST        ?= cpu.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary -j 0
PASS_MSG        := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and look for the pass message"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"
	@echo "Variables: TOP, FILELIST, VERILATOR, VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== dv/cpu_trace.txt ====
# I <byte address, hex> <instruction word, hex>
# C <test name> <rd, decimal> <expected value, hex>, in commit order
I 00000000 00500093  addi x1, x0, 5
I 00000004 ffd00113  addi x2, x0, -3
I 00000008 002081b3  add  x3, x1, x2
I 0000000c 40118233  sub  x4, x3, x1
I 00000010 001272b3  and  x5, x4, x1
I 00000014 0022e333  or   x6, x5, x2
I 00000018 001343b3  xor  x7, x6, x1
I 0000001c 0013a433  slt  x8, x7, x1
I 00000020 0070a4b3  slt  x9, x1, x7
I 00000024 12345537  lui  x10, 0x12345
I 00000028 fff50513  addi x10, x10, -1
I 0000002c 80000593  addi x11, x0, -2048
I 00000030 00a02423  sw   x10, 8(x0)
I 00000034 00102623  sw   x1, 12(x0)
I 00000038 00802603  lw   x12, 8(x0)
I 0000003c 00c02683  lw   x13, 12(x0)
I 00000040 00b02823  sw   x11, 16(x0)
I 00000044 01002703  lw   x14, 16(x0)
I 00000048 00d707b3  add  x15, x14, x13
I 0000004c 00700013  addi x0, x0, 7
I 00000050 00100833  add  x16, x0, x1
I 00000054 00208463  beq  x1, x2, +8
I 00000058 00100893  addi x17, x0, 1
I 0000005c 00d08663  beq  x1, x13, +12
I 00000060 06300913  addi x18, x0, 99
I 00000064 06200993  addi x19, x0, 98
I 00000068 02a00a13  addi x20, x0, 42
I 0000006c 00000063  beq  x0, x0, 0
C alu_addi 1 00000005
C imm_addi_neg 2 fffffffd
C alu_add 3 00000002
C alu_sub 4 fffffffd
C alu_and 5 00000005
C alu_or 6 fffffffd
C alu_xor 7 fffffff8
C alu_slt_true 8 00000001
C alu_slt_false 9 00000000
C imm_lui 10 12345000
C imm_addi_dep 10 12344fff
C imm_addi_min 11 fffff800
C mem_lw_first 12 12344fff
C mem_lw_second 13 00000005
C mem_lw_third 14 fffff800
C mem_load_use 15 fffff805
C x0_read 16 00000005
C branch_not_taken 17 00000001
C branch_target 20 0000002a

// ==== dv/cpu_tb.sv ====
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int    IMEM_WORDS   = 64;
    localparam int    IMEM_AW      = $clog2(IMEM_WORDS);
    localparam data_t NOP          = 32'h0000_0013;  // addi x0, x0, 0
    localparam int    RESET_CYCLES = 5;
    localparam int    QUIET_CYCLES = 20;
    localparam int    CYCLES_PER_COMMIT = 40;
    localparam logic [31:0] LCG_SEED = 32'd42348;
    localparam string TRACE_FILE   = "dv/cpu_trace.txt";

    logic        clock;
    logic        rst = 1'b1;
    logic        enable = 1'b1;
    data_t       imem_addr;
    data_t       imem_data;
    commit_t     commit;

    data_t       imem [IMEM_WORDS];
    string       exp_name [$];
    int          exp_rd [$];
    data_t       exp_value [$];
    int          total = 0;
    int          retired = 0;
    data_t       last_program_addr = '0;
    logic        trace_loaded = 1'b0;
    logic [31:0] lcg_state = LCG_SEED;

    cpu i_cpu (
        .clock(clock), .rst(rst), .enable(enable),
        .imem_addr(imem_addr), .imem_data(imem_data), .commit(commit)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Word aligned and inside the modelled ROM
    function automatic logic in_program_range(data_t addr);
        return (addr[1:0] == 2'b00) && (addr[31:IMEM_AW+2] == '0);
    endfunction

    task automatic stop_on_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_value(string test_name, data_t expected, data_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    rd;
        string line;
        string tag;
        string name;
        data_t addr;
        data_t word;
        data_t value;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP;
        end
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_FILE);
            stop_on_failure();
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    tag = "";  // Blank or comment line
                end else if ($sscanf(line, "%s", tag) != 1) begin
                    tag = "";
                end else if (tag == "I") begin
                    if ($sscanf(line, "%s %h %h", tag, addr, word) == 3 &&
                        in_program_range(addr)) begin
                        imem[addr[IMEM_AW+1:2]] = word;
                        if (addr > last_program_addr) begin
                            last_program_addr = addr;
                        end
                    end else begin
                        $display("Bad program line in the trace: %s", line);
                        stop_on_failure();
                    end
                end else if (tag == "C" &&
                             $sscanf(line, "%s %s %d %h", tag, name, rd, value) == 4) begin
                    exp_name.push_back(name);
                    exp_rd.push_back(rd);
                    exp_value.push_back(value);
                end else begin
                    $display("Unreadable line in the trace: %s", line);
                    stop_on_failure();
                end
            end
            $fclose(fd);
        end
        total = exp_name.size();
    endtask

    // Instruction ROM answers in the same cycle
    always_comb begin
        if (in_program_range(imem_addr)) begin
            imem_data = imem[imem_addr[IMEM_AW+1:2]];
        end else begin
            imem_data = NOP;
        end
    end

    // Pauses start once half the commits are in
    always @(posedge clock) begin
        if (rst || retired < total / 2) begin
            enable <= 1'b1;
        end else begin
            lcg_state = lcg_next(lcg_state);
            enable <= (lcg_state[17:16] != 2'b00);
        end
    end

    always @(negedge clock) begin
        if (!rst && commit.valid) begin
            if (exp_name.size() == 0) begin
                $display("Unexpected retirement after the last expected commit: x%0d = %h",
                         commit.rd, commit.value);
                stop_on_failure();
            end else begin
                compare_value({exp_name[0], " rd"}, data_t'(exp_rd[0]), data_t'(commit.rd));
                compare_value({exp_name[0], " value"}, exp_value[0], commit.value);
                void'(exp_name.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_value.pop_front());
                retired++;
            end
        end
    end

    // Fetch runs at most two slots past the final self-loop
    always @(negedge clock) begin
        if (!rst && (imem_addr[1:0] != 2'b00 ||
                     imem_addr > last_program_addr + data_t'(8))) begin
            $display("Fetch address %h is outside the program", imem_addr);
            stop_on_failure();
        end
    end

    initial begin
        int limit;
        wait (trace_loaded);
        limit = CYCLES_PER_COMMIT * total + RESET_CYCLES + QUIET_CYCLES;
        repeat (limit) @(posedge clock);
        $display("Timeout: only %0d of %0d expected commits after %0d cycles",
                 retired, total, limit);
        stop_on_failure();
    end

    initial begin
        load_trace();
        trace_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        compare_value("reset_pc", RESET_PC, imem_addr);
        while (retired < total) @(posedge clock);
        repeat (QUIET_CYCLES) @(posedge clock);  // Self-loop must stay silent
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/100ps

module cpu (
    input  logic             clock,
    input  logic             rst,
    input  logic             enable,
    output cpu_pkg::data_t   imem_addr,
    input  cpu_pkg::data_t   imem_data,
    output cpu_pkg::commit_t commit
);
    import cpu_pkg::*;

    fetch_t    if_out;
    fetch_t    if_de;
    decode_t   de_out;
    decode_t   de_ex;
    exmem_t    ex_out;
    exmem_t    ex_mem;
    commit_t   mem_out;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    data_t     rs1_value;
    data_t     rs2_value;
    data_t     branch_target;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    logic      hazard;
    logic      mem_busy;
    logic      redirect;
    logic      advance;
    logic      take_branch;

    assign advance     = enable && !mem_busy;  // r_ex_mem moves on this edge
    assign take_branch = redirect && advance;

    fetch i_fetch (
        .clock(clock), .rst(rst), .enable(enable), .stall(hazard || mem_busy),
        .redirect(take_branch), .branch_target(branch_target),
        .imem_addr(imem_addr), .imem_data(imem_data), .fetched(if_out)
    );

    stage_reg #(.payload_t(fetch_t)) r_if_de (
        .clock(clock), .rst(rst), .hold(!advance || hazard), .flush(take_branch),
        .d(if_out), .q(if_de)
    );

    decode i_decode (
        .clock(clock), .in_instr(if_de), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .ex_entry(de_ex),
        .mem_entry(ex_mem), .hazard(hazard), .decoded(de_out)
    );

    register_bank i_register_bank (
        .clock(clock), .rst(rst), .write(commit),
        .read_address1(rs1_addr), .read_address2(rs2_addr),
        .value1(rs1_value), .value2(rs2_value)
    );

    // Interlock bubble only when the older entry really leaves
    stage_reg #(.payload_t(decode_t)) r_de_ex (
        .clock(clock), .rst(rst), .hold(!advance),
        .flush((take_branch || hazard) && advance), .d(de_out), .q(de_ex)
    );

    execute i_execute (
        .in_entry(de_ex), .out_entry(ex_out),
        .redirect(redirect), .branch_target(branch_target)
    );

    stage_reg #(.payload_t(exmem_t)) r_ex_mem (
        .clock(clock), .rst(rst), .hold(!advance), .flush(1'b0),
        .d(ex_out), .q(ex_mem)
    );

    memory i_memory (
        .clock(clock), .rst(rst), .enable(enable), .in_entry(ex_mem),
        .mem_busy(mem_busy), .wb_req(wb_req), .wb_rsp(wb_rsp), .out_commit(mem_out)
    );

    data_ram i_data_ram (
        .clock(clock), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    // A paused cycle drops the commit once the bank has taken it
    stage_reg #(.payload_t(commit_t)) r_mem_wb (
        .clock(clock), .rst(rst), .hold(1'b0), .flush(!enable),
        .d(mem_out), .q(commit)
    );

endmodule

// ==== verilog/data_ram.sv ====
`timescale 1ns/100ps

module data_ram (
    input  logic             clock,
    input  logic             rst,
    input  cpu_pkg::wb_req_t wb_req,
    output cpu_pkg::wb_rsp_t wb_rsp
);
    import cpu_pkg::*;

    data_t                  mem [DRAM_WORDS];
    logic [DRAM_ADDR_W-1:0] index;
    logic                   req_seen;
    logic                   ack_q;
    data_t                  rdata_q;

    assign index    = wb_req.adr[DRAM_ADDR_W+1:2];  // Word aligned with upper bits ignored
    assign req_seen = wb_req.cyc && wb_req.stb;

    // One wait state and a single-cycle ack pulse
    always_ff @(posedge clock) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_seen && !ack_q;
        end
    end

    always_ff @(posedge clock) begin
        if (req_seen && !ack_q) begin
            rdata_q <= mem[index];
        end
        if (req_seen && ack_q && wb_req.we) begin
            mem[index] <= wb_req.dat;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdata_q;

endmodule

// ==== verilog/memory.sv ====
`timescale 1ns/100ps

module memory (
    input  logic             clock,
    input  logic             rst,
    input  logic             enable,
    input  cpu_pkg::exmem_t  in_entry,
    output logic             mem_busy,
    output cpu_pkg::wb_req_t wb_req,
    input  cpu_pkg::wb_rsp_t wb_rsp,
    output cpu_pkg::commit_t out_commit
);
    import cpu_pkg::*;

    // Waiting means acked but the pipeline was paused
    typedef enum logic {ST_IDLE, ST_WAIT} mem_state_e;

    mem_state_e state_q;
    logic       access;
    logic       issuing;
    data_t      load_q;
    data_t      load_data;

    assign access  = in_entry.valid && (in_entry.mem_read || in_entry.mem_write);
    assign issuing = access && (state_q == ST_IDLE);

    always_comb begin
        wb_req.cyc = issuing;
        wb_req.stb = issuing;
        wb_req.we  = in_entry.mem_write;
        wb_req.adr = in_entry.result;
        wb_req.dat = in_entry.store_data;
    end

    assign mem_busy = issuing && !wb_rsp.ack;

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (issuing && wb_rsp.ack && !enable) state_q <= ST_WAIT;
                ST_WAIT: if (enable) state_q <= ST_IDLE;  // Entry moves on this edge
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (wb_rsp.ack) begin
            load_q <= wb_rsp.dat;
        end
    end

    assign load_data = (state_q == ST_WAIT) ? load_q : wb_rsp.dat;

    always_comb begin
        out_commit.valid = in_entry.valid && in_entry.reg_write && !mem_busy;  // sw never
        out_commit.rd    = in_entry.rd;
        out_commit.value = in_entry.mem_read ? load_data : in_entry.result;
    end

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/100ps

module execute (
    input  cpu_pkg::decode_t in_entry,
    output cpu_pkg::exmem_t  out_entry,
    output logic             redirect,
    output cpu_pkg::data_t   branch_target
);
    import cpu_pkg::*;

    data_t operand_a;
    data_t operand_b;
    data_t alu_result;
    logic  less;

    assign operand_a = in_entry.rs1_value;
    assign operand_b = in_entry.use_imm ? in_entry.imm : in_entry.rs2_value;
    assign less      = $signed(operand_a) < $signed(operand_b);

    always_comb begin
        case (in_entry.alu_op)
            ALU_ADD:    alu_result = operand_a + operand_b;  // Also lw/sw address
            ALU_SUB:    alu_result = operand_a - operand_b;
            ALU_AND:    alu_result = operand_a & operand_b;
            ALU_OR:     alu_result = operand_a | operand_b;
            ALU_XOR:    alu_result = operand_a ^ operand_b;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, less};
            ALU_PASS_B: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    // beq compares the raw register values
    assign redirect = in_entry.valid && in_entry.branch &&
                      (in_entry.rs1_value == in_entry.rs2_value);
    assign branch_target = in_entry.pc + in_entry.imm;

    always_comb begin
        out_entry.valid      = in_entry.valid;
        out_entry.result     = alu_result;
        out_entry.store_data = in_entry.rs2_value;
        out_entry.rd         = in_entry.rd;
        out_entry.reg_write  = in_entry.reg_write;
        out_entry.mem_read   = in_entry.mem_read;
        out_entry.mem_write  = in_entry.mem_write;
    end

endmodule

// ==== verilog/register_bank.sv ====
`timescale 1ns/100ps

module register_bank (
    input  logic               clock,
    input  logic               rst,
    input  cpu_pkg::commit_t   write,
    input  cpu_pkg::reg_addr_t read_address1,
    input  cpu_pkg::reg_addr_t read_address2,
    output cpu_pkg::data_t     value1,
    output cpu_pkg::data_t     value2
);
    import cpu_pkg::*;

    data_t regs [2**REG_ADDR_W];

    // Same-cycle write shows through on the read side
    function automatic data_t read_port(reg_addr_t addr, commit_t wr, data_t stored);
        if (addr == '0) begin
            return '0;
        end
        if (wr.valid && (wr.rd == addr)) begin
            return wr.value;
        end
        return stored;
    endfunction

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (write.valid && (write.rd != '0)) begin
            regs[write.rd] <= write.value;  // x0 never written
        end
    end

    assign value1 = read_port(read_address1, write, regs[read_address1]);
    assign value2 = read_port(read_address2, write, regs[read_address2]);

endmodule

// ==== verilog/decode.sv ====
`timescale 1ns/100ps

module decode (
    input  logic               clock,
    input  cpu_pkg::fetch_t    in_instr,
    output cpu_pkg::reg_addr_t rs1_addr,
    output cpu_pkg::reg_addr_t rs2_addr,
    input  cpu_pkg::data_t     rs1_value,
    input  cpu_pkg::data_t     rs2_value,
    input  cpu_pkg::decode_t   ex_entry,
    input  cpu_pkg::exmem_t    mem_entry,
    output logic               hazard,
    output cpu_pkg::decode_t   decoded
);
    import cpu_pkg::*;

    data_t      instr;
    reg_addr_t  rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    data_t      imm_i;
    data_t      imm_s;
    data_t      imm_b;
    data_t      imm_u;
    logic       supported;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       rs1_busy;
    logic       rs2_busy;

    // Register still owed by an instruction in execute or memory
    function automatic logic owed(reg_addr_t addr, decode_t ex, exmem_t mem);
        logic from_ex;
        logic from_mem;
        from_ex  = ex.valid && ex.reg_write && (ex.rd == addr);
        from_mem = mem.valid && mem.reg_write && (mem.rd == addr);
        return (addr != '0) && (from_ex || from_mem);
    endfunction

    assign instr    = in_instr.instr;
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        supported         = 1'b0;
        uses_rs1          = 1'b0;
        uses_rs2          = 1'b0;
        decoded           = '0;
        decoded.pc        = in_instr.pc;
        decoded.rs1_value = rs1_value;
        decoded.rs2_value = rs2_value;
        decoded.rd        = rd;
        decoded.alu_op    = ALU_ADD;
        case (instr[6:0])
            OP_REG: begin
                uses_rs1          = 1'b1;
                uses_rs2          = 1'b1;
                decoded.reg_write = 1'b1;
                supported         = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: decoded.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: decoded.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: decoded.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: decoded.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: decoded.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: decoded.alu_op = ALU_SLT;
                    default:              supported      = 1'b0;
                endcase
            end
            OP_IMM: begin  // addi only
                uses_rs1          = 1'b1;
                decoded.imm       = imm_i;
                decoded.use_imm   = 1'b1;
                decoded.reg_write = 1'b1;
                supported         = (funct3 == 3'b000);
            end
            OP_LUI: begin
                decoded.imm       = imm_u;
                decoded.use_imm   = 1'b1;
                decoded.alu_op    = ALU_PASS_B;
                decoded.reg_write = 1'b1;
                supported         = 1'b1;
            end
            OP_LOAD: begin
                uses_rs1          = 1'b1;
                decoded.imm       = imm_i;
                decoded.use_imm   = 1'b1;
                decoded.mem_read  = 1'b1;
                decoded.reg_write = 1'b1;
                supported         = (funct3 == 3'b010);  // lw
            end
            OP_STORE: begin
                uses_rs1          = 1'b1;
                uses_rs2          = 1'b1;
                decoded.imm       = imm_s;
                decoded.use_imm   = 1'b1;
                decoded.mem_write = 1'b1;
                supported         = (funct3 == 3'b010);  // sw
            end
            OP_BRANCH: begin
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                decoded.imm    = imm_b;
                decoded.branch = 1'b1;
                supported      = (funct3 == 3'b000);  // beq
            end
            default: begin
                supported = 1'b0;  // Anything else is a bubble
            end
        endcase
        decoded.valid = in_instr.valid && supported;
        if (rd == '0) begin
            decoded.reg_write = 1'b0;
        end
    end

    assign rs1_busy = owed(rs1_addr, ex_entry, mem_entry);
    assign rs2_busy = owed(rs2_addr, ex_entry, mem_entry);

    // Interlock in place of forwarding
    assign hazard = decoded.valid && ((uses_rs1 && rs1_busy) || (uses_rs2 && rs2_busy));

endmodule

// ==== verilog/fetch.sv ====
`timescale 1ns/100ps

module fetch (
    input  logic            clock,
    input  logic            rst,
    input  logic            enable,
    input  logic            stall,
    input  logic            redirect,
    input  cpu_pkg::data_t  branch_target,
    output cpu_pkg::data_t  imem_addr,
    input  cpu_pkg::data_t  imem_data,
    output cpu_pkg::fetch_t fetched
);
    import cpu_pkg::*;

    data_t pc_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (enable) begin
            // Taken beq wins over a decode stall
            if (redirect) begin
                pc_q <= branch_target;
            end else if (!stall) begin
                pc_q <= pc_q + data_t'(4);
            end
        end
    end

    assign imem_addr = pc_q;  // ROM answers in the same cycle

    always_comb begin
        fetched.valid = 1'b1;
        fetched.pc    = pc_q;
        fetched.instr = imem_data;
    end

endmodule

// ==== verilog/stage_reg.sv ====
`timescale 1ns/100ps

// Pipeline buffer shared by all four stage boundaries
module stage_reg #(
    parameter type payload_t = cpu_pkg::fetch_t
) (
    input  logic     clock,
    input  logic     rst,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            q.valid <= 1'b0;  // Bubble keeps the stale payload bits
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DRAM_WORDS  = 256;
    localparam int DRAM_ADDR_W = $clog2(DRAM_WORDS);  // Word index into data_ram

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam data_t RESET_PC = '0;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        data_t pc;
        data_t instr;
    } fetch_t;

    typedef struct packed {
        logic      valid;
        data_t     pc;
        alu_op_e   alu_op;
        data_t     rs1_value;
        data_t     rs2_value;
        data_t     imm;
        logic      use_imm;    // Operand B from imm instead of rs2
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;     // beq
    } decode_t;

    typedef struct packed {
        logic      valid;
        data_t     result;      // ALU result or memory address
        data_t     store_data;
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
    } exmem_t;

    // One retired register write
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        data_t     value;
    } commit_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        data_t adr;
        data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

endpackage
